// ==== common/axil_sram_pkg.sv ====
package axil_sram_pkg;

  // byte address and data path of the AXI-Lite side
  localparam int AXIL_ADDR_W = 12;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

  // low address bits that select a byte within a word
  localparam int WORD_LSB = 2;

  // word side of the memory
  localparam int SRAM_ADDR_W = AXIL_ADDR_W - WORD_LSB;
  localparam int SRAM_DEPTH  = 1 << SRAM_ADDR_W;

  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
  typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;
  typedef logic [1:0]             axil_resp_t;

  // only response this subordinate ever returns
  localparam axil_resp_t RESP_OKAY = 2'b00;

  // grant held by the arbiter toward the memory port
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_READ,
    ARB_WRITE
  } arb_state_t;

endpackage

// ==== axil_sram/axil_sram_wr.sv ====
`timescale 1ns/1ps

module axil_sram_wr (
  input  logic                    clk,
  input  logic                    rst_n,

  input  axil_sram_pkg::axil_addr_t i_awaddr,
  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  axil_sram_pkg::axil_data_t i_wdata,
  input  axil_sram_pkg::axil_strb_t i_wstrb,
  input  logic                    i_wvalid,
  output logic                    o_wready,
  output axil_sram_pkg::axil_resp_t o_bresp,
  output logic                    o_bvalid,
  input  logic                    i_bready,

  output logic                    o_cmd_valid,
  input  logic                    i_cmd_ready,
  output axil_sram_pkg::sram_addr_t o_cmd_addr,
  output axil_sram_pkg::axil_data_t o_cmd_data,
  output axil_sram_pkg::axil_strb_t o_cmd_strb
);

  logic                      aw_full;
  logic                      w_full;
  axil_sram_pkg::sram_addr_t aw_addr_q;
  axil_sram_pkg::axil_data_t w_data_q;
  axil_sram_pkg::axil_strb_t w_strb_q;
  logic                      aw_fire;
  logic                      w_fire;
  logic                      cmd_fire;

  // nothing new is taken while a response is still outstanding
  assign o_awready = !aw_full && !o_bvalid;
  assign o_wready  = !w_full && !o_bvalid;

  assign aw_fire  = i_awvalid && o_awready;
  assign w_fire   = i_wvalid && o_wready;

  // command goes out once both halves are held
  assign o_cmd_valid = aw_full && w_full;
  assign cmd_fire    = o_cmd_valid && i_cmd_ready;

  assign o_cmd_addr = aw_addr_q;
  assign o_cmd_data = w_data_q;
  assign o_cmd_strb = w_strb_q;
  assign o_bresp    = axil_sram_pkg::RESP_OKAY;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_full  <= 1'b0;
      w_full   <= 1'b0;
      o_bvalid <= 1'b0;
    end else begin
      if (cmd_fire) begin
        aw_full <= 1'b0;
      end else if (aw_fire) begin
        aw_full <= 1'b1;
      end

      if (cmd_fire) begin
        w_full <= 1'b0;
      end else if (w_fire) begin
        w_full <= 1'b1;
      end

      // response rises on the edge after the memory takes the write
      if (cmd_fire) begin
        o_bvalid <= 1'b1;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
    end
  end

  // holding registers, byte offset dropped here
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      aw_addr_q <= i_awaddr[axil_sram_pkg::AXIL_ADDR_W-1:axil_sram_pkg::WORD_LSB];
    end
    if (w_fire) begin
      w_data_q <= i_wdata;
      w_strb_q <= i_wstrb;
    end
  end

endmodule

// ==== axil_sram/axil_sram_rd.sv ====
`timescale 1ns/1ps

module axil_sram_rd (
  input  logic                    clk,
  input  logic                    rst_n,

  input  axil_sram_pkg::axil_addr_t i_araddr,
  input  logic                    i_arvalid,
  output logic                    o_arready,
  output axil_sram_pkg::axil_data_t o_rdata,
  output axil_sram_pkg::axil_resp_t o_rresp,
  output logic                    o_rvalid,
  input  logic                    i_rready,

  output logic                    o_cmd_valid,
  input  logic                    i_cmd_ready,
  output axil_sram_pkg::sram_addr_t o_cmd_addr,
  input  logic                    i_resp_valid,
  output logic                    o_resp_ready,
  input  axil_sram_pkg::axil_data_t i_resp_data
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ISSUE,
    RD_WAIT,
    RD_RESP
  } rd_phase_t;

  rd_phase_t                 phase;
  axil_sram_pkg::sram_addr_t ar_addr_q;
  logic                      ar_fire;
  logic                      cmd_fire;
  logic                      data_fire;

  assign o_arready    = (phase == RD_IDLE);
  assign o_cmd_valid  = (phase == RD_ISSUE);
  assign o_resp_ready = (phase == RD_WAIT);
  assign o_rvalid     = (phase == RD_RESP);

  assign ar_fire   = i_arvalid && o_arready;
  assign cmd_fire  = o_cmd_valid && i_cmd_ready;
  assign data_fire = i_resp_valid && o_resp_ready;

  assign o_cmd_addr = ar_addr_q;
  assign o_rresp    = axil_sram_pkg::RESP_OKAY;

  // one read in flight, idle -> issue -> wait -> resp
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= RD_IDLE;
    end else begin
      case (phase)
        RD_IDLE: begin
          if (ar_fire) begin
            phase <= RD_ISSUE;
          end
        end
        RD_ISSUE: begin
          if (cmd_fire) begin
            phase <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          if (data_fire) begin
            phase <= RD_RESP;
          end
        end
        default: begin
          if (i_rready) begin
            phase <= RD_IDLE;
          end
        end
      endcase
    end
  end

  // word address and returned data
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      ar_addr_q <= i_araddr[axil_sram_pkg::AXIL_ADDR_W-1:axil_sram_pkg::WORD_LSB];
    end
    if (data_fire) begin
      o_rdata <= i_resp_data;
    end
  end

endmodule

// ==== axil_sram/axil_sram_arb.sv ====
`timescale 1ns/1ps

module axil_sram_arb (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    i_wr_valid,
  output logic                    o_wr_ready,
  input  axil_sram_pkg::sram_addr_t i_wr_addr,

  input  logic                    i_rd_valid,
  output logic                    o_rd_ready,
  input  axil_sram_pkg::sram_addr_t i_rd_addr,

  output logic                    o_sram_valid,
  input  logic                    i_sram_ready,
  output axil_sram_pkg::sram_addr_t o_sram_addr,
  output logic                    o_sram_wr_en
);

  axil_sram_pkg::arb_state_t state;
  axil_sram_pkg::arb_state_t fair;
  axil_sram_pkg::arb_state_t grant;
  logic                      pri_read;
  logic                      wr_done;
  logic                      rd_done;

  // pick a side; reads only win right after a write went through
  always_comb begin
    fair = axil_sram_pkg::ARB_IDLE;
    if (pri_read) begin
      if (i_rd_valid) begin
        fair = axil_sram_pkg::ARB_READ;
      end else if (i_wr_valid) begin
        fair = axil_sram_pkg::ARB_WRITE;
      end
    end else begin
      if (i_wr_valid) begin
        fair = axil_sram_pkg::ARB_WRITE;
      end else if (i_rd_valid) begin
        fair = axil_sram_pkg::ARB_READ;
      end
    end
  end

  // a grant that stalled stays put so the command on the port is stable
  always_comb begin
    if (state == axil_sram_pkg::ARB_IDLE) begin
      grant = fair;
    end else begin
      grant = state;
    end
  end

  assign wr_done = (grant == axil_sram_pkg::ARB_WRITE) && i_sram_ready;
  assign rd_done = (grant == axil_sram_pkg::ARB_READ) && i_sram_ready;

  // command mux onto the single port
  always_comb begin
    o_sram_valid = 1'b0;
    o_sram_addr  = '0;
    o_sram_wr_en = 1'b0;
    o_wr_ready   = 1'b0;
    o_rd_ready   = 1'b0;
    case (grant)
      axil_sram_pkg::ARB_WRITE: begin
        o_sram_valid = 1'b1;
        o_sram_addr  = i_wr_addr;
        o_sram_wr_en = 1'b1;
        o_wr_ready   = i_sram_ready;
      end
      axil_sram_pkg::ARB_READ: begin
        o_sram_valid = 1'b1;
        o_sram_addr  = i_rd_addr;
        o_rd_ready   = i_sram_ready;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= axil_sram_pkg::ARB_IDLE;
      pri_read <= 1'b0;
    end else begin
      if (grant != axil_sram_pkg::ARB_IDLE && !i_sram_ready) begin
        state <= grant;
      end else begin
        state <= axil_sram_pkg::ARB_IDLE;
      end

      if (wr_done) begin
        pri_read <= 1'b1;
      end else if (rd_done) begin
        pri_read <= 1'b0;
      end
    end
  end

endmodule

// ==== src/sram_store.sv ====
`timescale 1ns/1ps

module sram_store (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    i_cmd_valid,
  output logic                    o_cmd_ready,
  input  axil_sram_pkg::sram_addr_t i_cmd_addr,
  input  logic                    i_cmd_wr_en,
  input  axil_sram_pkg::axil_data_t i_cmd_data,
  input  axil_sram_pkg::axil_strb_t i_cmd_strb,

  output logic                    o_resp_valid,
  input  logic                    i_resp_ready,
  output axil_sram_pkg::axil_data_t o_resp_data
);

  axil_sram_pkg::axil_data_t mem [axil_sram_pkg::SRAM_DEPTH];
  logic                      cmd_fire;

  // stall while a read result sits unread
  assign o_cmd_ready = !o_resp_valid;
  assign cmd_fire    = i_cmd_valid && o_cmd_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int w = 0; w < axil_sram_pkg::SRAM_DEPTH; w++) begin
        mem[w] <= '0;
      end
    end else if (cmd_fire && i_cmd_wr_en) begin
      // per-lane write enables
      for (int b = 0; b < axil_sram_pkg::AXIL_STRB_W; b++) begin
        if (i_cmd_strb[b]) begin
          mem[i_cmd_addr][b*8 +: 8] <= i_cmd_data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_resp_valid <= 1'b0;
    end else if (cmd_fire && !i_cmd_wr_en) begin
      o_resp_valid <= 1'b1;
    end else if (i_resp_ready) begin
      o_resp_valid <= 1'b0;
    end
  end

  // read data registered with the accepting edge
  always_ff @(posedge clk) begin
    if (cmd_fire && !i_cmd_wr_en) begin
      o_resp_data <= mem[i_cmd_addr];
    end
  end

endmodule

// ==== src/axil_sram_top.sv ====
`timescale 1ns/1ps

module axil_sram_top (
  input  logic                    clk,
  input  logic                    rst_n,

  input  axil_sram_pkg::axil_addr_t i_awaddr,
  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  axil_sram_pkg::axil_data_t i_wdata,
  input  axil_sram_pkg::axil_strb_t i_wstrb,
  input  logic                    i_wvalid,
  output logic                    o_wready,
  output axil_sram_pkg::axil_resp_t o_bresp,
  output logic                    o_bvalid,
  input  logic                    i_bready,

  input  axil_sram_pkg::axil_addr_t i_araddr,
  input  logic                    i_arvalid,
  output logic                    o_arready,
  output axil_sram_pkg::axil_data_t o_rdata,
  output axil_sram_pkg::axil_resp_t o_rresp,
  output logic                    o_rvalid,
  input  logic                    i_rready
);

  // write side to arbiter; data and strobes bypass it
  logic                      wr_cmd_valid;
  logic                      wr_cmd_ready;
  axil_sram_pkg::sram_addr_t wr_cmd_addr;
  axil_sram_pkg::axil_data_t wr_cmd_data;
  axil_sram_pkg::axil_strb_t wr_cmd_strb;

  logic                      rd_cmd_valid;
  logic                      rd_cmd_ready;
  axil_sram_pkg::sram_addr_t rd_cmd_addr;

  logic                      sram_cmd_valid;
  logic                      sram_cmd_ready;
  axil_sram_pkg::sram_addr_t sram_cmd_addr;
  logic                      sram_cmd_wr_en;

  // read data path back from the store
  logic                      rd_resp_valid;
  logic                      rd_resp_ready;
  axil_sram_pkg::axil_data_t rd_resp_data;

  axil_sram_wr u_wr (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_awaddr    (i_awaddr),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_wvalid    (i_wvalid),
    .o_wready    (o_wready),
    .o_bresp     (o_bresp),
    .o_bvalid    (o_bvalid),
    .i_bready    (i_bready),
    .o_cmd_valid (wr_cmd_valid),
    .i_cmd_ready (wr_cmd_ready),
    .o_cmd_addr  (wr_cmd_addr),
    .o_cmd_data  (wr_cmd_data),
    .o_cmd_strb  (wr_cmd_strb)
  );

  axil_sram_rd u_rd (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_araddr     (i_araddr),
    .i_arvalid    (i_arvalid),
    .o_arready    (o_arready),
    .o_rdata      (o_rdata),
    .o_rresp      (o_rresp),
    .o_rvalid     (o_rvalid),
    .i_rready     (i_rready),
    .o_cmd_valid  (rd_cmd_valid),
    .i_cmd_ready  (rd_cmd_ready),
    .o_cmd_addr   (rd_cmd_addr),
    .i_resp_valid (rd_resp_valid),
    .o_resp_ready (rd_resp_ready),
    .i_resp_data  (rd_resp_data)
  );

  axil_sram_arb u_arb (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_wr_valid   (wr_cmd_valid),
    .o_wr_ready   (wr_cmd_ready),
    .i_wr_addr    (wr_cmd_addr),
    .i_rd_valid   (rd_cmd_valid),
    .o_rd_ready   (rd_cmd_ready),
    .i_rd_addr    (rd_cmd_addr),
    .o_sram_valid (sram_cmd_valid),
    .i_sram_ready (sram_cmd_ready),
    .o_sram_addr  (sram_cmd_addr),
    .o_sram_wr_en (sram_cmd_wr_en)
  );

  sram_store u_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_cmd_valid  (sram_cmd_valid),
    .o_cmd_ready  (sram_cmd_ready),
    .i_cmd_addr   (sram_cmd_addr),
    .i_cmd_wr_en  (sram_cmd_wr_en),
    .i_cmd_data   (wr_cmd_data),
    .i_cmd_strb   (wr_cmd_strb),
    .o_resp_valid (rd_resp_valid),
    .i_resp_ready (rd_resp_ready),
    .o_resp_data  (rd_resp_data)
  );

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  localparam int HALF_PERIOD_NS = 10;
  localparam int RESET_CYCLES   = 4;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
  end

  // release a little after the edge like the rest of the stimulus
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #2;
    o_rst_n = 1'b1;
  end

endmodule

// ==== bench/axil_sram_props.sv ====
`timescale 1ns/1ps

module axil_sram_props (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      i_awvalid,
  input logic                      i_awready,
  input axil_sram_pkg::axil_addr_t i_awaddr,
  input logic                      i_wvalid,
  input logic                      i_wready,
  input axil_sram_pkg::axil_data_t i_wdata,
  input axil_sram_pkg::axil_strb_t i_wstrb,
  input logic                      i_bvalid,
  input logic                      i_bready,
  input axil_sram_pkg::axil_resp_t i_bresp,
  input logic                      i_arvalid,
  input logic                      i_arready,
  input axil_sram_pkg::axil_addr_t i_araddr,
  input logic                      i_rvalid,
  input logic                      i_rready,
  input axil_sram_pkg::axil_data_t i_rdata,
  input logic                      i_cmd_valid,
  input logic                      i_cmd_ready,
  input axil_sram_pkg::sram_addr_t i_cmd_addr,
  input logic                      i_cmd_wr_en
);

  // manager side channels
  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
    else $error("awvalid dropped or awaddr changed before the handshake");

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wstrb))
    else $error("wvalid dropped or write data changed before the handshake");

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
    else $error("arvalid dropped or araddr changed before the handshake");

  // subordinate side channels
  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
    else $error("bvalid dropped or bresp changed before the handshake");

  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
    else $error("rvalid dropped or rdata changed before the handshake");

  // internal memory port, grant held while stalled
  cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_cmd_valid && !i_cmd_ready |=> i_cmd_valid && $stable(i_cmd_addr)
      && $stable(i_cmd_wr_en))
    else $error("memory command changed while stalled");

  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> !i_bvalid && !i_rvalid && !i_cmd_valid)
    else $error("valid high in the cycle after reset");

endmodule

// ==== bench/axil_sram_tb.sv ====
`timescale 1ns/1ps

module axil_sram_tb;

  localparam int CLK_PERIOD_NS = 20;
  // a few hundred cycles of tests and a wide margin
  localparam int TEST_CYCLES   = 10000;
  localparam int TIMEOUT_NS    = TEST_CYCLES * CLK_PERIOD_NS;
  localparam int SEED          = 32'h4a9c_53bc;

  localparam int ORDER_BOTH       = 0;
  localparam int ORDER_ADDR_FIRST = 1;
  localparam int ORDER_DATA_FIRST = 2;

  logic                      clk;
  logic                      rst_n;
  axil_sram_pkg::axil_addr_t awaddr;
  logic                      awvalid;
  logic                      awready;
  axil_sram_pkg::axil_data_t wdata;
  axil_sram_pkg::axil_strb_t wstrb;
  logic                      wvalid;
  logic                      wready;
  axil_sram_pkg::axil_resp_t bresp;
  logic                      bvalid;
  logic                      bready;
  axil_sram_pkg::axil_addr_t araddr;
  logic                      arvalid;
  logic                      arready;
  axil_sram_pkg::axil_data_t rdata;
  axil_sram_pkg::axil_resp_t rresp;
  logic                      rvalid;
  logic                      rready;

  // expected memory contents per word
  axil_sram_pkg::axil_data_t shadow [axil_sram_pkg::SRAM_DEPTH];
  // set by a completed write and cleared by a granted read
  bit                        rd_first;
  int                        data_errs;
  int                        resp_errs;
  int                        proto_errs;
  bit                        timed_out;
  bit                        verdict_done;

  tb_clk_gen u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  axil_sram_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_awaddr  (awaddr),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .o_bresp   (bresp),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .i_araddr  (araddr),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .o_rvalid  (rvalid),
    .i_rready  (rready)
  );

  bind axil_sram_top axil_sram_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_awvalid   (i_awvalid),
    .i_awready   (o_awready),
    .i_awaddr    (i_awaddr),
    .i_wvalid    (i_wvalid),
    .i_wready    (o_wready),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_bvalid    (o_bvalid),
    .i_bready    (i_bready),
    .i_bresp     (o_bresp),
    .i_arvalid   (i_arvalid),
    .i_arready   (o_arready),
    .i_araddr    (i_araddr),
    .i_rvalid    (o_rvalid),
    .i_rready    (i_rready),
    .i_rdata     (o_rdata),
    .i_cmd_valid (sram_cmd_valid),
    .i_cmd_ready (sram_cmd_ready),
    .i_cmd_addr  (sram_cmd_addr),
    .i_cmd_wr_en (sram_cmd_wr_en)
  );

  function automatic axil_sram_pkg::sram_addr_t word_of(input axil_sram_pkg::axil_addr_t a);
    return a[axil_sram_pkg::AXIL_ADDR_W-1:axil_sram_pkg::WORD_LSB];
  endfunction

  // byte lanes with their strobe set take the new data
  function automatic axil_sram_pkg::axil_data_t merge_lanes(
    input axil_sram_pkg::axil_data_t old_word,
    input axil_sram_pkg::axil_data_t new_word,
    input axil_sram_pkg::axil_strb_t strb
  );
    axil_sram_pkg::axil_data_t m;
    m = old_word;
    for (int b = 0; b < axil_sram_pkg::AXIL_STRB_W; b++) begin
      if (strb[b]) begin
        m[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return m;
  endfunction

  task automatic check_data(input axil_sram_pkg::axil_data_t got,
                            input axil_sram_pkg::axil_data_t exp, input string what);
    if (got !== exp) begin
      data_errs++;
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input axil_sram_pkg::axil_resp_t got,
                            input axil_sram_pkg::axil_resp_t exp, input string what);
    if (got !== exp) begin
      resp_errs++;
      $display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic send_aw(input axil_sram_pkg::axil_addr_t addr);
    awaddr  = addr;
    awvalid = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    next_cycle();
    awvalid = 1'b0;
  endtask

  task automatic send_w(input axil_sram_pkg::axil_data_t data,
                        input axil_sram_pkg::axil_strb_t strb);
    wdata  = data;
    wstrb  = strb;
    wvalid = 1'b1;
    @(negedge clk);
    while (!wready) @(negedge clk);
    next_cycle();
    wvalid = 1'b0;
  endtask

  task automatic send_ar(input axil_sram_pkg::axil_addr_t addr);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    next_cycle();
    arvalid = 1'b0;
  endtask

  // hold > 0 keeps bready low that many cycles after bvalid rises
  task automatic take_b(input int hold);
    bready = (hold == 0);
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    check_resp(bresp, axil_sram_pkg::RESP_OKAY, "bresp");
    for (int n = 0; n < hold; n++) begin
      @(negedge clk);
      if (!bvalid) begin
        proto_errs++;
        $display("bvalid fell while bready was held low, at time %0t", $time);
      end
    end
    if (hold > 0) begin
      next_cycle();
      bready = 1'b1;
    end
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic take_r(input axil_sram_pkg::axil_data_t exp, input int hold);
    rready = (hold == 0);
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    check_resp(rresp, axil_sram_pkg::RESP_OKAY, "rresp");
    check_data(rdata, exp, "rdata");
    for (int n = 0; n < hold; n++) begin
      @(negedge clk);
      if (!rvalid) begin
        proto_errs++;
        $display("rvalid fell while rready was held low, at time %0t", $time);
      end
      check_data(rdata, exp, "stalled rdata");
    end
    if (hold > 0) begin
      next_cycle();
      rready = 1'b1;
    end
    next_cycle();
    rready = 1'b0;
  endtask

  task automatic do_write(input axil_sram_pkg::axil_addr_t addr,
                          input axil_sram_pkg::axil_data_t data,
                          input axil_sram_pkg::axil_strb_t strb,
                          input int order, input int hold);
    case (order)
      ORDER_ADDR_FIRST: begin
        send_aw(addr);
        repeat (3) next_cycle();
        send_w(data, strb);
      end
      ORDER_DATA_FIRST: begin
        send_w(data, strb);
        repeat (3) next_cycle();
        send_aw(addr);
      end
      default: begin
        fork
          send_aw(addr);
          send_w(data, strb);
        join
      end
    endcase
    take_b(hold);
    shadow[word_of(addr)] = merge_lanes(shadow[word_of(addr)], data, strb);
    rd_first = 1'b1;
  endtask

  task automatic do_read(input axil_sram_pkg::axil_addr_t addr, input int hold);
    send_ar(addr);
    take_r(shadow[word_of(addr)], hold);
    rd_first = 1'b0;
  endtask

  // full-word write and read of one word launched in the same cycle
  task automatic race_pair(input axil_sram_pkg::axil_addr_t waddr,
                           input axil_sram_pkg::axil_addr_t raddr,
                           input axil_sram_pkg::axil_data_t data);
    axil_sram_pkg::axil_data_t exp;
    if (rd_first) begin
      exp = shadow[word_of(raddr)];
    end else begin
      exp = data;
    end
    fork
      send_aw(waddr);
      send_w(data, 4'hf);
      send_ar(raddr);
    join
    fork
      take_b(0);
      take_r(exp, 0);
    join
    shadow[word_of(waddr)] = data;
    // flag ends as it was in either order
  endtask

  task automatic test_reset_zero();
    do_read(12'h000, 0);
    do_read(12'h004, 0);
    do_read(12'h7f8, 0);
    do_read(12'hffc, 0);
  endtask

  task automatic test_full_word();
    do_write(12'h100, $urandom(), 4'hf, ORDER_BOTH, 0);
    do_read(12'h100, 0);
    // byte offsets land on the same word
    do_read(12'h103, 0);
    do_write(12'h20a, $urandom(), 4'hf, ORDER_BOTH, 0);
    do_read(12'h208, 0);
  endtask

  task automatic test_partial_strobes();
    axil_sram_pkg::axil_strb_t lanes [4];
    lanes = '{4'b0001, 4'b0100, 4'b1010, 4'b0110};
    do_write(12'h180, $urandom(), 4'hf, ORDER_BOTH, 0);
    for (int i = 0; i < 4; i++) begin
      do_write(12'h180, $urandom(), lanes[i], ORDER_BOTH, 0);
      do_read(12'h180, 0);
    end
  endtask

  task automatic test_handshake_orders();
    do_write(12'h300, $urandom(), 4'hf, ORDER_ADDR_FIRST, 0);
    do_write(12'h304, $urandom(), 4'hf, ORDER_DATA_FIRST, 0);
    do_write(12'h308, $urandom(), 4'b0011, ORDER_BOTH, 0);
    do_read(12'h300, 0);
    do_read(12'h304, 0);
    do_read(12'h308, 0);
  endtask

  task automatic test_backpressure();
    do_write(12'h400, $urandom(), 4'hf, ORDER_BOTH, 12);
    do_read(12'h400, 12);
  endtask

  task automatic test_collision();
    race_pair(12'h500, 12'h501, $urandom());
    // a lone write leaves the read-priority flag set
    do_write(12'h600, $urandom(), 4'hf, ORDER_BOTH, 0);
    race_pair(12'h500, 12'h500, $urandom());
    do_read(12'h500, 0);
  endtask

  task automatic run_tests();
    test_reset_zero();
    test_full_word();
    test_partial_strobes();
    test_handshake_orders();
    test_backpressure();
    test_collision();
  endtask

  task automatic wait_timeout();
    #(TIMEOUT_NS);
    timed_out = 1'b1;
  endtask

  initial begin
    void'($urandom(SEED));
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int w = 0; w < axil_sram_pkg::SRAM_DEPTH; w++) begin
      shadow[w] = '0;
    end
    wait (rst_n === 1'b1);
    fork
      run_tests();
      wait_timeout();
    join_any
    if (timed_out) begin
      $display("watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
    end
    $display("errors: %0d data, %0d response, %0d protocol",
             data_errs, resp_errs, proto_errs);
    verdict_done = 1'b1;
    if (!timed_out && data_errs == 0 && resp_errs == 0 && proto_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  final begin
    if (!verdict_done) begin
      $display("Test failures found");
    end
  end

endmodule

// ==== filelist.f ====
common/axil_sram_pkg.sv
axil_sram/axil_sram_wr.sv
axil_sram/axil_sram_rd.sv
axil_sram/axil_sram_arb.sv
src/sram_store.sv
src/axil_sram_top.sv
bench/tb_clk_gen.sv
bench/axil_sram_props.sv
bench/axil_sram_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= axil_sram_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
